// ==== build.f ====
source/gnn_pkg.sv
source/mem_port_if.sv
source/bank_port_if.sv
source/edge_pe.sv
source/graph_memory.sv
source/aggregation_bank.sv
source/gnn_aggr_top.sv
sim/gnn_aggr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module gnn_aggr_tb -o gnn_aggr_sim

out=$(./obj_dir/gnn_aggr_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

// ==== sim/gnn_aggr_tb.sv ====
`timescale 1ns/100ps

module gnn_aggr_tb import gnn_pkg::*; ();

    localparam int num_tests = 10;

    logic              clk = 1'b0;
    logic              reset;
    logic [1:0]        task_valid;
    logic [node_w-1:0] task_node;
    logic [1:0]        pe_idle;
    logic              result_valid;
    logic [node_w-1:0] result_node;
    logic [sum_w-1:0]  result_lo;
    logic [sum_w-1:0]  result_hi;

    // name, element (2 means both at once), node, drain before next
    string names [num_tests] = '{"deg2_pe0", "deg4_pe1", "deg6_pe1", "deg8_pe1", "both_same",
                                 "pair_a", "pair_b", "overlap_a", "overlap_b", "overlap_c"};
    int    elems [num_tests] = '{0, 1, 1, 1, 2, 0, 1, 1, 0, 1};
    int    nodes [num_tests] = '{4, 5, 10, 127, 39, 66, 93, 3, 16, 50};
    int    drain [num_tests] = '{1, 1, 1, 1, 1, 0, 1, 0, 0, 1};

    // scoreboard of outstanding tasks
    string      sb_name [$];
    int         sb_node [$];
    logic [1:0] sb_mask [$];
    int         sb_lo [$];
    int         sb_hi [$];
    int         sb_issued [$];

    int cycle_count = 0;
    int idle_at0 = 0;
    int idle_at1 = 0;

    gnn_aggr_top i_gnn_aggr_top (
        .clk         (clk),
        .reset       (reset),
        .task_valid  (task_valid),
        .task_node   (task_node),
        .pe_idle     (pe_idle),
        .result_valid(result_valid),
        .result_node (result_node),
        .result_lo   (result_lo),
        .result_hi   (result_hi)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    function automatic int expect_lo(input int n);
        int sum;
        int k;
        int m;
        sum = 0;
        for (k = 0; k < (n % 4) * 2 + 2; k++) begin
            m = (n + 1 + 9 * k) % 128;
            sum += (7 * m) % 256;
        end
        return sum;
    endfunction

    function automatic int expect_hi(input int n);
        int sum;
        int k;
        int m;
        sum = 0;
        for (k = 0; k < (n % 4) * 2 + 2; k++) begin
            m = (n + 1 + 9 * k) % 128;
            sum += m ^ 'ha5;
        end
        return sum;
    endfunction

    task automatic push_expect(input string name, input int node, input logic [1:0] mask);
        sb_name.push_back(name);
        sb_node.push_back(node);
        sb_mask.push_back(mask);
        sb_lo.push_back(expect_lo(node));
        sb_hi.push_back(expect_hi(node));
        sb_issued.push_back(cycle_count);
    endtask

    task automatic issue_task(input string name, input int elem, input int node);
        logic [1:0] mask;
        int         waited;
        mask   = (elem == 2) ? 2'b11 : ((elem == 1) ? 2'b10 : 2'b01);
        waited = 0;
        while ((pe_idle & mask) != mask) begin
            @(negedge clk);
            waited++;
            if (waited > 1000) abort_run($sformatf("%s: element never went idle", name));
        end
        task_node  = node_w'(node);
        task_valid = mask;
        if (mask[0]) push_expect(name, node, 2'b01);
        if (mask[1]) push_expect(name, node, 2'b10);
        @(negedge clk);
        task_valid = 2'b00;
        check_value($sformatf("%s idle drop", name), 0, int'(pe_idle & mask));
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (sb_node.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 2000) abort_run("results still outstanding after timeout");
        end
    endtask

    // result monitor sampled mid-cycle
    always @(negedge clk) begin
        int idx;
        int i;
        logic ok;
        if (!reset) begin
            if (pe_idle[0]) idle_at0 = cycle_count;
            if (pe_idle[1]) idle_at1 = cycle_count;
            if (result_valid) begin
                idx = -1;
                for (i = 0; i < sb_node.size(); i++) begin
                    if (idx < 0 && sb_node[i] == int'(result_node)) idx = i;
                end
                if (idx < 0) abort_run($sformatf("result for node %0d that was never issued",
                                                 result_node));
                check_value({sb_name[idx], " lo"}, sb_lo[idx], int'(result_lo));
                check_value({sb_name[idx], " hi"}, sb_hi[idx], int'(result_hi));
                ok = (!sb_mask[idx][0] || idle_at0 > sb_issued[idx]) &&
                     (!sb_mask[idx][1] || idle_at1 > sb_issued[idx]);
                check_value({sb_name[idx], " idle back"}, 1, int'(ok));
                sb_name.delete(idx);
                sb_node.delete(idx);
                sb_mask.delete(idx);
                sb_lo.delete(idx);
                sb_hi.delete(idx);
                sb_issued.delete(idx);
            end
        end
    end

    initial begin
        reset      = 1'b1;
        task_valid = 2'b00;
        task_node  = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("reset idle", 3, int'(pe_idle));
        check_value("reset result_valid", 0, int'(result_valid));
        for (int t = 0; t < num_tests; t++) begin
            issue_task(names[t], elems[t], nodes[t]);
            if (drain[t] != 0) wait_drained();
        end
        wait_drained();
        $display("test passed");
        $finish;
    end

endmodule

// ==== source/aggregation_bank.sv ====
`timescale 1ns/100ps

module aggregation_bank import gnn_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    bank_port_if.bank         in0,
    bank_port_if.bank         in1,
    output logic              result_valid,
    output logic [node_w-1:0] result_node,
    output logic [sum_w-1:0]  result_lo,
    output logic [sum_w-1:0]  result_hi
);

    logic [num_pe-1:0] valid;
    logic [num_pe-1:0] sos;
    logic [num_pe-1:0] eos;
    logic [num_pe-1:0] done;
    logic [lane_w-1:0] lo [num_pe];
    logic [lane_w-1:0] hi [num_pe];
    logic [sum_w-1:0]  acc_lo [num_pe];
    logic [sum_w-1:0]  acc_hi [num_pe];
    logic              pending;    // element 1 result held back one cycle
    logic [node_w-1:0] pend_node;

    assign valid = {in1.valid, in0.valid};
    assign sos   = {in1.sos, in0.sos};
    assign eos   = {in1.eos, in0.eos};
    assign done  = {in1.done, in0.done};
    assign lo[0] = in0.lo;
    assign lo[1] = in1.lo;
    assign hi[0] = in0.hi;
    assign hi[1] = in1.hi;

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_pe; i++) begin
            if (valid[i]) begin
                if (sos[i]) begin
                    acc_lo[i] <= sum_w'(lo[i]);
                    acc_hi[i] <= sum_w'(hi[i]);
                end else begin
                    acc_lo[i] <= acc_lo[i] + sum_w'(lo[i]);
                    acc_hi[i] <= acc_hi[i] + sum_w'(hi[i]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            pending      <= 1'b0;
        end else begin
            result_valid <= pending || (|done);
            pending      <= done[0] && done[1];
        end
    end

    always_ff @(posedge clk) begin
        if (done[1]) pend_node <= in1.node;  // element may restart before it drains
        if (pending) begin
            result_node <= pend_node;
            result_lo   <= acc_lo[1];
            result_hi   <= acc_hi[1];
        end else if (done[0]) begin
            result_node <= in0.node;
            result_lo   <= acc_lo[0];
            result_hi   <= acc_hi[0];
        end else if (done[1]) begin
            result_node <= in1.node;
            result_lo   <= acc_lo[1];
            result_hi   <= acc_hi[1];
        end
    end

    a_back_to_back: assert property (@(posedge clk) disable iff (reset)
        result_valid && !pending |=> !result_valid);

    // done trails the last feature beat by one cycle
    a_done_after_eos: assert property (@(posedge clk) disable iff (reset)
        done == $past(valid & eos));

endmodule

// ==== source/bank_port_if.sv ====
`timescale 1ns/100ps

interface bank_port_if import gnn_pkg::*; ();

    logic              valid;
    logic              sos;
    logic              eos;
    logic [lane_w-1:0] lo;
    logic [lane_w-1:0] hi;
    logic              done;
    logic [node_w-1:0] node;  // target node when done is high

    modport pe (
        output valid, sos, eos, lo, hi, done, node
    );

    modport bank (
        input valid, sos, eos, lo, hi, done, node
    );

endinterface

// ==== source/edge_pe.sv ====
`timescale 1ns/100ps

module edge_pe import gnn_pkg::*; #(
    parameter int pe_tag = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              task_valid,
    input  logic [node_w-1:0] task_node,
    output logic              idle,
    mem_port_if.pe            mem,
    bank_port_if.pe           bank
);

    pe_state_t         state;
    logic [node_w-1:0] target;
    logic [node_w-1:0] nbr [max_degree];
    logic [cnt_w-1:0]  cnt;     // neighbor ids received
    logic [cnt_w-1:0]  ptr;     // feature requests granted
    logic [cnt_w-2:0]  wr_idx;
    logic              id_beat;
    logic              fv_beat;

    assign idle      = (state == st_idle);
    assign wr_idx    = cnt[cnt_w-2:0];
    assign id_beat   = (state == st_wait_ids && mem.sos) || state == st_stream_ids;
    assign fv_beat   = (state == st_wait_fv) && mem.eos;
    assign bank.node = target;

    // request lines follow the state
    always_comb begin
        mem.req      = 1'b0;
        mem.req_type = rt_ids;
        mem.node     = target;
        case (state)
            st_req_ids: mem.req = 1'b1;
            st_req_fv: begin
                mem.req      = 1'b1;
                mem.req_type = rt_fv;
                mem.node     = nbr[ptr[cnt_w-2:0]];
            end
            default: mem.req = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            cnt        <= '0;
            ptr        <= '0;
            bank.valid <= 1'b0;
            bank.sos   <= 1'b0;
            bank.eos   <= 1'b0;
            bank.done  <= 1'b0;
        end else begin
            bank.valid <= 1'b0;
            bank.sos   <= 1'b0;
            bank.eos   <= 1'b0;
            bank.done  <= 1'b0;
            case (state)
                st_idle: begin
                    if (task_valid) begin
                        state <= st_req_ids;
                        cnt   <= '0;
                        ptr   <= '0;
                    end
                end
                st_req_ids: begin
                    if (mem.grant) state <= st_wait_ids;
                end
                st_wait_ids, st_stream_ids: begin
                    if (id_beat) begin
                        cnt   <= cnt + cnt_w'(2);
                        state <= mem.eos ? st_req_fv : st_stream_ids;
                    end
                end
                st_req_fv: begin
                    if (mem.grant) begin
                        ptr   <= ptr + 1'b1;
                        state <= st_wait_fv;
                    end
                end
                st_wait_fv: begin
                    if (fv_beat) begin
                        bank.valid <= 1'b1;
                        bank.sos   <= (ptr == cnt_w'(1));  // first neighbor clears sums
                        bank.eos   <= (ptr == cnt);
                        state      <= (ptr == cnt) ? st_done : st_req_fv;
                    end
                end
                st_done: begin
                    bank.done <= 1'b1;
                    state     <= st_idle;  // idle rises with done
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && task_valid) target <= task_node;
        if (id_beat) begin
            nbr[wr_idx]        <= mem.ids[0];
            nbr[wr_idx + 1'b1] <= mem.ids[1];
        end
        if (fv_beat) begin
            bank.lo <= mem.fv[0];
            bank.hi <= mem.fv[1];
        end
    end

    // memory must not see a request or hand out a grant to an idle element
    a_quiet_idle: assert property (@(posedge clk) disable iff (reset)
        idle |-> !mem.req && !mem.grant)
        else $error("edge_pe %0d: memory traffic while idle", pe_tag);

endmodule

// ==== source/gnn_aggr_top.sv ====
`timescale 1ns/100ps

module gnn_aggr_top import gnn_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [num_pe-1:0] task_valid,
    input  logic [node_w-1:0] task_node,
    output logic [num_pe-1:0] pe_idle,
    output logic              result_valid,
    output logic [node_w-1:0] result_node,
    output logic [sum_w-1:0]  result_lo,
    output logic [sum_w-1:0]  result_hi
);

    mem_port_if  mem0 ();
    mem_port_if  mem1 ();
    bank_port_if bank0 ();
    bank_port_if bank1 ();

    edge_pe #(
        .pe_tag(0)
    ) i_edge_pe0 (
        .clk       (clk),
        .reset     (reset),
        .task_valid(task_valid[0]),
        .task_node (task_node),
        .idle      (pe_idle[0]),
        .mem       (mem0.pe),
        .bank      (bank0.pe)
    );

    edge_pe #(
        .pe_tag(1)
    ) i_edge_pe1 (
        .clk       (clk),
        .reset     (reset),
        .task_valid(task_valid[1]),
        .task_node (task_node),
        .idle      (pe_idle[1]),
        .mem       (mem1.pe),
        .bank      (bank1.pe)
    );

    graph_memory i_graph_memory (
        .clk  (clk),
        .reset(reset),
        .port0(mem0.mem),
        .port1(mem1.mem)
    );

    aggregation_bank i_aggregation_bank (
        .clk         (clk),
        .reset       (reset),
        .in0         (bank0.bank),
        .in1         (bank1.bank),
        .result_valid(result_valid),
        .result_node (result_node),
        .result_lo   (result_lo),
        .result_hi   (result_hi)
    );

endmodule

// ==== source/gnn_pkg.sv ====
package gnn_pkg;

    localparam int node_w     = 7;
    localparam int max_degree = 8;
    localparam int cnt_w      = 4;
    localparam int lane_w     = 8;
    localparam int sum_w      = 12;
    localparam int num_pe     = 2;
    localparam int mem_lat    = 2;  // grant to first reply beat

    typedef enum logic {
        rt_ids = 1'b0,
        rt_fv  = 1'b1
    } req_type_t;

    typedef enum logic [3:0] {
        st_idle       = 4'd0,
        st_req_ids    = 4'd1,
        st_wait_ids   = 4'd2,
        st_stream_ids = 4'd3,
        st_req_fv     = 4'd4,
        st_wait_fv    = 4'd5,
        st_done       = 4'd6
    } pe_state_t;

    // 2, 4, 6 or 8 neighbors
    function automatic logic [cnt_w-1:0] degree(input logic [node_w-1:0] n);
        return cnt_w'(2 * n[1:0] + 2);
    endfunction

    function automatic logic [node_w-1:0] nbr_id(input logic [node_w-1:0] n,
                                                 input logic [cnt_w-1:0] k);
        return node_w'(32'(n) + 32'd1 + 32'd9 * 32'(k));
    endfunction

    function automatic logic [lane_w-1:0] feat_lo(input logic [node_w-1:0] m);
        return lane_w'(32'd7 * 32'(m));
    endfunction

    function automatic logic [lane_w-1:0] feat_hi(input logic [node_w-1:0] m);
        return lane_w'(m) ^ 8'ha5;
    endfunction

endpackage

// ==== source/graph_memory.sv ====
`timescale 1ns/100ps

module graph_memory import gnn_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    mem_port_if.mem port0,
    mem_port_if.mem port1
);

    logic                   busy;
    logic                   owner;     // port being served
    logic                   rr;        // port1 has priority when set
    logic                   pick1;
    logic [cnt_w-1:0]       delay;
    logic [cnt_w-1:0]       beat;
    logic [cnt_w-1:0]       last;
    logic [cnt_w-1:0]       k0;
    logic [node_w-1:0]      node;
    logic [node_w-1:0]      win_node;
    logic                   win_ids;
    logic                   beat_on;
    logic [1:0][node_w-1:0] ids;
    logic [1:0][lane_w-1:0] fv;

    assign pick1       = port1.req && (rr || !port0.req);
    assign port0.grant = !busy && port0.req && !pick1;
    assign port1.grant = !busy && pick1;

    assign win_node = pick1 ? port1.node : port0.node;
    assign win_ids  = (pick1 ? port1.req_type : port0.req_type) == rt_ids;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            rr    <= 1'b0;
            delay <= '0;
            beat  <= '0;
        end else if (!busy) begin
            if (port0.grant || port1.grant) begin
                busy  <= 1'b1;
                owner <= pick1;
                rr    <= !pick1;  // loser goes first next time
                delay <= cnt_w'(mem_lat - 1);
                beat  <= '0;
            end
        end else if (delay != '0) begin
            delay <= delay - 1'b1;
        end else if (beat == last) begin
            busy <= 1'b0;
        end else begin
            beat <= beat + 1'b1;
        end
    end

    // request payload latched while free
    always_ff @(posedge clk) begin
        if (!busy) begin
            node <= win_node;
            last <= win_ids ? cnt_w'((degree(win_node) >> 1) - 1) : '0;
        end
    end

    assign beat_on = busy && (delay == '0);
    assign k0      = cnt_w'(beat << 1);

    always_comb begin
        ids[0] = nbr_id(node, k0);
        ids[1] = nbr_id(node, k0 + cnt_w'(1));
        fv[0]  = feat_lo(node);
        fv[1]  = feat_hi(node);
    end

    assign port0.ids = ids;
    assign port1.ids = ids;
    assign port0.fv  = fv;
    assign port1.fv  = fv;
    assign port0.sos = beat_on && !owner && beat == '0;
    assign port0.eos = beat_on && !owner && beat == last;
    assign port1.sos = beat_on && owner && beat == '0;
    assign port1.eos = beat_on && owner && beat == last;

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        !(port0.grant && port1.grant));

    // every grant is answered after the fixed latency
    a_reply_lat: assert property (@(posedge clk) disable iff (reset)
        (port0.grant || port1.grant) |-> ##mem_lat (port0.sos || port1.sos));

endmodule

// ==== source/mem_port_if.sv ====
`timescale 1ns/100ps

interface mem_port_if import gnn_pkg::*; ();

    logic                   req;
    req_type_t              req_type;
    logic [node_w-1:0]      node;
    logic                   grant;     // one cycle pulse
    logic                   sos;
    logic                   eos;
    logic [1:0][node_w-1:0] ids;       // two neighbor ids per beat
    logic [1:0][lane_w-1:0] fv;        // lo lane, hi lane

    modport pe (
        output req, req_type, node,
        input  grant, sos, eos, ids, fv
    );

    modport mem (
        input  req, req_type, node,
        output grant, sos, eos, ids, fv
    );

endinterface
